/* src/qm_depth_pkg.sv */
// ====================
// shared sizes and types for the queue depth subsystem
// import it with a wildcard import in each module header
// ====================

package qm_depth_pkg;

	// ====================
	// sizes
	// ====================

	localparam int qid_nbits = 4;
	localparam int num_queues = 16;
	// depth counts wrap modulo 256, there is no saturation
	localparam int depth_nbits = 8;

	localparam int enq_fifo_depth = 4;
	localparam int enq_ptr_nbits = $clog2(enq_fifo_depth);
	localparam int enq_cnt_nbits = $clog2(enq_fifo_depth + 1);

	// address bit 4 picks the status word, low bits pick a queue
	localparam int wb_adr_nbits = 5;
	localparam int wb_dat_nbits = 8;

	// ====================
	// request and event types
	// ====================

	typedef struct packed {
		logic valid;
		logic [qid_nbits-1:0] qid;
	} qm_req_t;

	typedef struct packed {
		logic ack;
		logic [qid_nbits-1:0] qid;
		logic to_empty;
	} qm_enq_evt_t;

	typedef struct packed {
		logic ack;
		logic [qid_nbits-1:0] qid;
		logic from_emptyp2;
	} qm_deq_evt_t;

	typedef struct packed {
		logic en;
		logic [qid_nbits-1:0] addr;
		logic [depth_nbits-1:0] data;
	} ram_wr_t;

	// ====================
	// wishbone classic
	// ====================

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [wb_adr_nbits-1:0] adr;
		logic [wb_dat_nbits-1:0] dat;
	} wb_m2s_t;

	typedef struct packed {
		logic ack;
		logic [wb_dat_nbits-1:0] dat;
	} wb_s2m_t;

endpackage

/* src/qm_depth_init_fsm.sv */
// ====================
// clears every depth entry once after reset
// drives its own RAM write request and raises ready when the sweep is over
// ====================

module qm_depth_init_fsm import qm_depth_pkg::*; (
	input logic clk,
	input logic rst_n,
	output ram_wr_t init_wr,
	output logic ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_sweep,
		st_done
	} init_state_t;

	init_state_t state;
	init_state_t state_nxt;
	logic [qid_nbits-1:0] sweep_addr;
	logic sweep_last;

	assign sweep_last = (sweep_addr == qid_nbits'(num_queues - 1));

	// ====================
	// next state
	// ====================

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: state_nxt = st_sweep;
			st_sweep: begin
				if (sweep_last) begin
					state_nxt = st_done;
				end
			end
			st_done: state_nxt = st_done;
			default: state_nxt = st_idle;
		endcase
	end

	// ====================
	// state, counter and ready
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			sweep_addr <= '0;
			ready <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == st_sweep) begin
				sweep_addr <= sweep_addr + 1'b1;
			end
			// ready follows done by one cycle, so the last clear has landed
			ready <= (state == st_done);
		end
	end

	// one zero write per cycle while sweeping
	assign init_wr.en = (state == st_sweep);
	assign init_wr.addr = sweep_addr;
	assign init_wr.data = '0;

endmodule

/* src/qm_enq_latency_fifo.sv */
// ====================
// small FIFO that holds enqueue requests until the pipeline has a free slot
// the head shows the oldest entry, a push into a full FIFO is lost
// ====================

module qm_enq_latency_fifo import qm_depth_pkg::*; (
	input logic clk,
	input logic rst_n,
	input qm_req_t push,
	input logic pop,
	output qm_req_t head,
	output logic overflow
);

	logic [qid_nbits-1:0] mem [enq_fifo_depth];
	logic [enq_ptr_nbits-1:0] wr_ptr;
	logic [enq_ptr_nbits-1:0] rd_ptr;
	logic [enq_cnt_nbits-1:0] count;
	logic full;
	logic empty;
	logic do_push;
	logic do_pop;

	assign full = (count == enq_cnt_nbits'(enq_fifo_depth));
	assign empty = (count == '0);
	// a full FIFO drops the push even when a pop happens in the same cycle
	assign do_push = push.valid && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			overflow <= push.valid && full;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push.qid;
		end
	end

	assign head.valid = !empty;
	assign head.qid = mem[rd_ptr];

endmodule

/* src/qm_depth_ram.sv */
// ====================
// depth storage, one write port and two registered read ports
// the pipeline reads one port, the host the other
// ====================

module qm_depth_ram import qm_depth_pkg::*; (
	input logic clk,
	input ram_wr_t wr,
	input logic [qid_nbits-1:0] raddr,
	output logic [depth_nbits-1:0] rdata,
	input logic [qid_nbits-1:0] host_raddr,
	output logic [depth_nbits-1:0] host_rdata
);

	logic [depth_nbits-1:0] mem [num_queues];

	// contents are defined by the sweep after reset
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// a read in the same cycle as a write to that entry returns the old value
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

	always_ff @(posedge clk) begin
		host_rdata <= mem[host_raddr];
	end

endmodule

/* src/qm_depth_update.sv */
// ====================
// three stage read-modify-write of the depth counts with forwarding
// dequeues win stage 1, enqueues come from the latency FIFO
// ====================

module qm_depth_update import qm_depth_pkg::*; (
	input logic clk,
	input logic rst_n,
	input qm_req_t enq,
	input qm_req_t deq,
	output qm_req_t fifo_push,
	output logic fifo_pop,
	input qm_req_t fifo_head,
	output logic [qid_nbits-1:0] ram_raddr,
	input logic [depth_nbits-1:0] ram_rdata,
	output ram_wr_t ram_wr,
	output qm_enq_evt_t enq_evt,
	output qm_deq_evt_t deq_evt
);

	logic enq_d1_valid;
	logic [qid_nbits-1:0] enq_d1_qid;

	logic s1_valid;
	logic [qid_nbits-1:0] s1_qid;

	logic s2_valid;
	logic s2_is_deq;
	logic [qid_nbits-1:0] s2_qid;

	logic s3_valid;
	logic s3_is_deq;
	logic [qid_nbits-1:0] s3_qid;
	logic [depth_nbits-1:0] s3_depth;
	logic s3_flag;

	logic s4_valid;
	logic [qid_nbits-1:0] s4_qid;
	logic [depth_nbits-1:0] s4_depth;

	logic hit_s3;
	logic hit_s4;
	logic [depth_nbits-1:0] old_depth;
	logic [depth_nbits-1:0] new_depth;
	logic flag;

	// enqueues enter the FIFO one cycle after the request
	assign fifo_push = '{valid: enq_d1_valid, qid: enq_d1_qid};

	// ====================
	// stage 1: arbitration and RAM read
	// ====================

	assign s1_valid = deq.valid || fifo_head.valid;
	assign s1_qid = deq.valid ? deq.qid : fifo_head.qid;
	assign fifo_pop = fifo_head.valid && !deq.valid;
	assign ram_raddr = s1_qid;

	// ====================
	// stage 2: forwarding and new depth
	// ====================

	// stage 3 is written at the end of this cycle, stage 4 was written one cycle ago
	// and the RAM read that went with this operation missed both
	assign hit_s3 = s3_valid && (s3_qid == s2_qid);
	assign hit_s4 = s4_valid && (s4_qid == s2_qid);

	always_comb begin
		if (hit_s3) begin
			old_depth = s3_depth;
		end else if (hit_s4) begin
			old_depth = s4_depth;
		end else begin
			old_depth = ram_rdata;
		end
	end

	assign new_depth = s2_is_deq ? old_depth - 1'b1 : old_depth + 1'b1;
	// from_emptyp2 for a dequeue, to_empty for an enqueue
	assign flag = s2_is_deq ? (old_depth > depth_nbits'(1)) : (old_depth == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enq_d1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s4_valid <= 1'b0;
		end else begin
			enq_d1_valid <= enq.valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
			s4_valid <= s3_valid;
		end
	end

	always_ff @(posedge clk) begin
		enq_d1_qid <= enq.qid;
		s2_is_deq <= deq.valid;
		s2_qid <= s1_qid;
		s3_is_deq <= s2_is_deq;
		s3_qid <= s2_qid;
		s3_depth <= new_depth;
		s3_flag <= flag;
		s4_qid <= s3_qid;
		s4_depth <= s3_depth;
	end

	// ====================
	// stage 3: write back and events
	// ====================

	assign ram_wr = '{en: s3_valid, addr: s3_qid, data: s3_depth};
	assign enq_evt = '{ack: s3_valid && !s3_is_deq, qid: s3_qid, to_empty: s3_flag};
	assign deq_evt = '{ack: s3_valid && s3_is_deq, qid: s3_qid, from_emptyp2: s3_flag};

endmodule

/* src/qm_depth_wb_port.sv */
// ====================
// wishbone classic slave for host depth reads and the status word
// keeps the sticky overflow flag, a status write with bit 0 set clears it
// ====================

module qm_depth_wb_port import qm_depth_pkg::*; (
	input logic clk,
	input logic rst_n,
	input wb_m2s_t wb_i,
	output wb_s2m_t wb_o,
	input logic ready,
	input logic overflow,
	output logic [qid_nbits-1:0] host_raddr,
	input logic [depth_nbits-1:0] host_rdata
);

	typedef enum logic [1:0] {
		wb_idle,
		wb_wait,
		wb_ack,
		wb_hold
	} wb_state_t;

	wb_state_t state;
	logic req;
	logic sel_status;
	logic clr_ovf;
	logic ovf_flag;
	logic [wb_dat_nbits-1:0] status_word;
	logic [wb_dat_nbits-1:0] rd_data;

	assign req = wb_i.cyc && wb_i.stb;
	assign sel_status = wb_i.adr[wb_adr_nbits-1];
	assign host_raddr = wb_i.adr[qid_nbits-1:0];
	assign status_word = {{(wb_dat_nbits - 2){1'b0}}, ready, ovf_flag};
	assign clr_ovf = (state == wb_wait) && wb_i.we && sel_status && wb_i.dat[0];

	// idle, one wait cycle for the RAM, one ack cycle, then hold until stb drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= wb_idle;
			ovf_flag <= 1'b0;
		end else begin
			case (state)
				wb_idle: state <= (req && ready) ? wb_wait : wb_idle;
				wb_wait: state <= req ? wb_ack : wb_idle;
				wb_ack: state <= wb_hold;
				default: state <= req ? wb_hold : wb_idle;
			endcase
			// a new overflow wins over a clear in the same cycle
			if (overflow) begin
				ovf_flag <= 1'b1;
			end else if (clr_ovf) begin
				ovf_flag <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == wb_wait) begin
			rd_data <= sel_status ? status_word : wb_dat_nbits'(host_rdata);
		end
	end

	assign wb_o = '{ack: (state == wb_ack), dat: rd_data};

endmodule

/* src/qm_depth_top.sv */
// ====================
// queue depth subsystem, connects the sweep, FIFO, RAM, pipeline and host port
// callers give enqueue and dequeue notices only while ready is high
// ====================

module qm_depth_top import qm_depth_pkg::*; (
	input logic clk,
	input logic rst_n,
	input qm_req_t enq,
	input qm_req_t deq,
	output qm_enq_evt_t enq_evt,
	output qm_deq_evt_t deq_evt,
	input wb_m2s_t wb_i,
	output wb_s2m_t wb_o,
	output logic ready
);

	ram_wr_t init_wr;
	ram_wr_t upd_wr;
	ram_wr_t ram_wr;
	qm_req_t fifo_push;
	qm_req_t fifo_head;
	logic fifo_pop;
	logic overflow;
	logic [qid_nbits-1:0] ram_raddr;
	logic [depth_nbits-1:0] ram_rdata;
	logic [qid_nbits-1:0] host_raddr;
	logic [depth_nbits-1:0] host_rdata;

	// the sweep owns the write port while it runs
	assign ram_wr = init_wr.en ? init_wr : upd_wr;

	qm_depth_init_fsm u_init (
		.clk(clk),
		.rst_n(rst_n),
		.init_wr(init_wr),
		.ready(ready)
	);

	qm_enq_latency_fifo u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(fifo_push),
		.pop(fifo_pop),
		.head(fifo_head),
		.overflow(overflow)
	);

	qm_depth_ram u_ram (
		.clk(clk),
		.wr(ram_wr),
		.raddr(ram_raddr),
		.rdata(ram_rdata),
		.host_raddr(host_raddr),
		.host_rdata(host_rdata)
	);

	qm_depth_update u_update (
		.clk(clk),
		.rst_n(rst_n),
		.enq(enq),
		.deq(deq),
		.fifo_push(fifo_push),
		.fifo_pop(fifo_pop),
		.fifo_head(fifo_head),
		.ram_raddr(ram_raddr),
		.ram_rdata(ram_rdata),
		.ram_wr(upd_wr),
		.enq_evt(enq_evt),
		.deq_evt(deq_evt)
	);

	qm_depth_wb_port u_wb (
		.clk(clk),
		.rst_n(rst_n),
		.wb_i(wb_i),
		.wb_o(wb_o),
		.ready(ready),
		.overflow(overflow),
		.host_raddr(host_raddr),
		.host_rdata(host_rdata)
	);

endmodule

/* verification/qm_depth_chk.sv */
// ====================
// handshake and timing assertions, bound into every qm_depth_top instance
// ====================

module qm_depth_chk import qm_depth_pkg::*; (
	input logic clk,
	input logic rst_n,
	input qm_req_t enq,
	input qm_req_t deq,
	input qm_deq_evt_t deq_evt,
	input wb_m2s_t wb_i,
	input wb_s2m_t wb_o,
	input logic ready
);

	// set once the current transfer has seen its ack, cleared when stb drops
	logic acked;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acked <= 1'b0;
		end else if (!(wb_i.cyc && wb_i.stb)) begin
			acked <= 1'b0;
		end else if (wb_o.ack) begin
			acked <= 1'b1;
		end
	end

	// a dequeue is acknowledged exactly two cycles after its request
	deq_ack_follows: assert property (@(posedge clk) disable iff (!rst_n)
		$past(deq.valid, 2) |-> deq_evt.ack)
		else $error("dequeue request not acknowledged two cycles later");

	deq_ack_has_request: assert property (@(posedge clk) disable iff (!rst_n)
		deq_evt.ack |-> $past(deq.valid, 2))
		else $error("dequeue ack without a request two cycles earlier");

	// one ack per transfer, no second one until the master drops stb
	wb_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
		wb_o.ack |-> !acked)
		else $error("wishbone ack given twice in one transfer");

	req_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!ready |-> !(enq.valid || deq.valid))
		else $error("request given while ready is low");

endmodule

bind qm_depth_top qm_depth_chk i_chk (
	.clk(clk),
	.rst_n(rst_n),
	.enq(enq),
	.deq(deq),
	.deq_evt(deq_evt),
	.wb_i(wb_i),
	.wb_o(wb_o),
	.ready(ready)
);

/* verification/qm_depth_tb.sv */
// ====================
// directed testbench for the queue depth subsystem, builds from list.f
// ends with a line of error counts and the overall result
// ====================

module qm_depth_tb import qm_depth_pkg::*; ();

	localparam int clk_period = 8;
	localparam int reset_cycles = 16;
	localparam logic [wb_adr_nbits-1:0] status_adr = 5'h10;
	localparam logic [qid_nbits-1:0] same_qid = 4'd5;
	localparam logic [qid_nbits-1:0] ovf_qid = 4'd9;

	// rough cycle budget of each test, the watchdog allows four times the sum
	localparam int len_reset = 40;
	localparam int len_after_reset = 100;
	localparam int len_single = 160;
	localparam int len_same_queue = 150;
	localparam int len_pressure = 200;
	localparam int len_overflow = 150;
	localparam int watchdog_cycles = 4 * (len_reset + len_after_reset + len_single
		+ len_same_queue + len_pressure + len_overflow);

	logic clk;
	logic rst_n;
	qm_req_t enq;
	qm_req_t deq;
	qm_enq_evt_t enq_evt;
	qm_deq_evt_t deq_evt;
	wb_m2s_t wb_i;
	wb_s2m_t wb_o;
	logic ready;

	int seed;
	int cyc_cnt;
	int check_cnt;
	int value_errs;
	int other_errs;

	// reference depths, updated in the order the events come out
	logic [depth_nbits-1:0] model [num_queues];
	// entries that a new dequeue may safely take
	int avail [num_queues];
	logic [qid_nbits-1:0] exp_enq_qid [$];
	logic [qid_nbits-1:0] exp_deq_qid [$];
	int exp_deq_cyc [$];

	qm_depth_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.enq(enq),
		.deq(deq),
		.enq_evt(enq_evt),
		.deq_evt(deq_evt),
		.wb_i(wb_i),
		.wb_o(wb_o),
		.ready(ready)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// counts at the falling edge so that both edges read a settled value
	always @(negedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("checks: %0d, value errors: %0d, other errors: %0d",
			check_cnt, value_errs, other_errs);
		$display("TESTS FAILED");
		$finish;
	end

	// ====================
	// compare tasks
	// ====================

	task automatic check_enq_evt(input qm_enq_evt_t got, input qm_enq_evt_t exp);
		check_cnt++;
		if (got.qid !== exp.qid) begin
			value_errs++;
			$display("ERROR enq_evt.qid: got 0x%h expected 0x%h", got.qid, exp.qid);
		end
		if (got.to_empty !== exp.to_empty) begin
			value_errs++;
			$display("ERROR enq_evt.to_empty: got 0x%h expected 0x%h",
				got.to_empty, exp.to_empty);
		end
	endtask

	task automatic check_deq_evt(input qm_deq_evt_t got, input qm_deq_evt_t exp);
		check_cnt++;
		if (got.qid !== exp.qid) begin
			value_errs++;
			$display("ERROR deq_evt.qid: got 0x%h expected 0x%h", got.qid, exp.qid);
		end
		if (got.from_emptyp2 !== exp.from_emptyp2) begin
			value_errs++;
			$display("ERROR deq_evt.from_emptyp2: got 0x%h expected 0x%h",
				got.from_emptyp2, exp.from_emptyp2);
		end
	endtask

	task automatic check_wb_data(input logic [wb_dat_nbits-1:0] got,
		input logic [wb_dat_nbits-1:0] exp, input string what);
		check_cnt++;
		if (got !== exp) begin
			value_errs++;
			$display("ERROR wb_o.dat %s: got 0x%h expected 0x%h", what, got, exp);
		end
	endtask

	// ====================
	// event monitor
	// ====================

	task automatic watch_enq();
		logic [qid_nbits-1:0] q;
		qm_enq_evt_t exp;
		if (exp_enq_qid.size() == 0) begin
			other_errs++;
			$display("enqueue event for queue %0d came with no request pending", enq_evt.qid);
		end else begin
			q = exp_enq_qid.pop_front();
			exp = '{ack: 1'b1, qid: q, to_empty: (model[q] == '0)};
			check_enq_evt(enq_evt, exp);
			model[q] = model[q] + 1'b1;
			avail[q]++;
		end
	endtask

	task automatic watch_deq();
		logic [qid_nbits-1:0] q;
		int c;
		qm_deq_evt_t exp;
		if (exp_deq_qid.size() == 0) begin
			other_errs++;
			$display("dequeue event for queue %0d came with no request pending", deq_evt.qid);
		end else begin
			q = exp_deq_qid.pop_front();
			c = exp_deq_cyc.pop_front();
			check_cnt++;
			if (cyc_cnt != c + 2) begin
				other_errs++;
				$display("dequeue event for queue %0d came %0d cycles after its request, not 2",
					q, cyc_cnt - c);
			end
			exp = '{ack: 1'b1, qid: q, from_emptyp2: (model[q] > 8'd1)};
			check_deq_evt(deq_evt, exp);
			model[q] = model[q] - 1'b1;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (enq_evt.ack) begin
				watch_enq();
			end
			if (deq_evt.ack) begin
				watch_deq();
			end
		end
	end

	// ====================
	// drive helpers
	// ====================

	// one cycle of requests, keep_enq is low for a push that the full FIFO will drop
	task automatic drive_ops(input logic do_enq, input logic [qid_nbits-1:0] eq,
		input logic keep_enq, input logic do_deq, input logic [qid_nbits-1:0] dq);
		@(posedge clk);
		enq <= '{valid: do_enq, qid: eq};
		deq <= '{valid: do_deq, qid: dq};
		if (do_enq && keep_enq) begin
			exp_enq_qid.push_back(eq);
		end
		if (do_deq) begin
			exp_deq_qid.push_back(dq);
			exp_deq_cyc.push_back(cyc_cnt);
			avail[dq]--;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_ops(1'b0, '0, 1'b0, 1'b0, '0);
	endtask

	task automatic single_op(input logic is_deq, input logic [qid_nbits-1:0] q);
		drive_ops(!is_deq, q, 1'b1, is_deq, q);
		idle_cycles(6);
	endtask

	task automatic pick_deq(output logic ok, output logic [qid_nbits-1:0] q);
		logic [qid_nbits-1:0] c;
		int tries;
		ok = 1'b0;
		q = '0;
		tries = 0;
		while (!ok && tries < 32) begin
			c = qid_nbits'($random(seed));
			if (avail[c] > 0) begin
				ok = 1'b1;
				q = c;
			end
			tries++;
		end
	endtask

	// waits for every pending event, then lets the last writes land
	task automatic settle();
		int n;
		idle_cycles(1);
		n = 0;
		while ((exp_enq_qid.size() != 0 || exp_deq_qid.size() != 0) && n < 64) begin
			@(posedge clk);
			n++;
		end
		if (exp_enq_qid.size() != 0 || exp_deq_qid.size() != 0) begin
			other_errs++;
			$display("events still missing after 64 cycles: %0d enqueue, %0d dequeue",
				exp_enq_qid.size(), exp_deq_qid.size());
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic wb_xfer(input logic we, input logic [wb_adr_nbits-1:0] adr,
		input logic [wb_dat_nbits-1:0] wdat, output logic [wb_dat_nbits-1:0] rdat);
		int n;
		logic seen;
		@(posedge clk);
		wb_i <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		n = 0;
		seen = 1'b0;
		rdat = '0;
		while (!seen && n < 16) begin
			@(negedge clk);
			n++;
			if (wb_o.ack) begin
				seen = 1'b1;
				rdat = wb_o.dat;
			end
		end
		if (!seen) begin
			other_errs++;
			$display("no Wishbone ack within 16 cycles at address 0x%h", adr);
		end
		@(posedge clk);
		wb_i <= '0;
	endtask

	task automatic check_depths();
		logic [wb_dat_nbits-1:0] d;
		for (int q = 0; q < num_queues; q++) begin
			wb_xfer(1'b0, wb_adr_nbits'(q), '0, d);
			check_wb_data(d, model[q], $sformatf("depth[%0d]", q));
		end
	endtask

	task automatic check_status(input logic [wb_dat_nbits-1:0] exp);
		logic [wb_dat_nbits-1:0] d;
		wb_xfer(1'b0, status_adr, '0, d);
		check_wb_data(d, exp, "status");
	endtask

	// ====================
	// tests
	// ====================

	task automatic do_reset();
		int start;
		int n;
		repeat (reset_cycles) @(negedge clk);
		if (enq_evt.ack || deq_evt.ack || wb_o.ack || ready) begin
			other_errs++;
			$display("an ack or ready is high while reset is held");
		end
		@(posedge clk);
		rst_n <= 1'b1;
		start = cyc_cnt;
		n = 0;
		while (!ready && n < 64) begin
			@(negedge clk);
			n++;
		end
		check_cnt++;
		if (!ready) begin
			other_errs++;
			$display("ready never rose after reset");
		end else if (cyc_cnt - start != num_queues + 2) begin
			other_errs++;
			$display("ready rose %0d cycles after reset instead of %0d",
				cyc_cnt - start, num_queues + 2);
		end
	endtask

	task automatic test_after_reset();
		check_depths();
		check_status(8'h02);
	endtask

	task automatic test_single_ops();
		single_op(1'b0, 4'd1);
		single_op(1'b0, 4'd2);
		single_op(1'b0, 4'd1);
		single_op(1'b1, 4'd1);
		single_op(1'b0, 4'd7);
		single_op(1'b1, 4'd2);
		single_op(1'b1, 4'd1);
		single_op(1'b1, 4'd7);
		single_op(1'b0, 4'd1);
		settle();
		check_depths();
	endtask

	// every cycle touches the same queue, so stage 2 forwards from both later stages
	task automatic test_same_queue();
		repeat (6) drive_ops(1'b1, same_qid, 1'b1, 1'b0, '0);
		settle();
		for (int i = 0; i < 16; i++) begin
			if (i % 2 == 0) begin
				drive_ops(1'b1, same_qid, 1'b1, 1'b0, '0);
			end else begin
				drive_ops(1'b0, '0, 1'b0, avail[same_qid] > 0, same_qid);
			end
		end
		repeat (3) drive_ops(1'b0, '0, 1'b0, avail[same_qid] > 0, same_qid);
		repeat (3) drive_ops(1'b1, same_qid, 1'b1, 1'b0, '0);
		drive_ops(1'b1, same_qid, 1'b1, avail[same_qid] > 0, same_qid);
		settle();
		check_depths();
	endtask

	task automatic test_deq_pressure();
		logic ok;
		logic [qid_nbits-1:0] dq;
		repeat (32) drive_ops(1'b1, qid_nbits'($random(seed)), 1'b1, 1'b0, '0);
		settle();
		// one free slot in four lets each enqueue out
		for (int i = 0; i < 24; i++) begin
			pick_deq(ok, dq);
			drive_ops(i % 4 == 0, qid_nbits'($random(seed)), 1'b1, ok && (i % 4 != 3), dq);
		end
		for (int i = 0; i < 8; i++) begin
			pick_deq(ok, dq);
			drive_ops(i < 3, qid_nbits'($random(seed)), 1'b1, ok, dq);
		end
		settle();
		check_depths();
		check_status(8'h02);
	endtask

	// dequeues block every pop, so only the first four pushes fit
	task automatic test_overflow();
		logic [wb_dat_nbits-1:0] d;
		repeat (10) drive_ops(1'b1, ovf_qid, 1'b1, 1'b0, '0);
		settle();
		for (int i = 0; i < 10; i++) begin
			drive_ops(i < 6, qid_nbits'(i), i < 4, 1'b1, ovf_qid);
		end
		settle();
		check_status(8'h03);
		wb_xfer(1'b1, status_adr, 8'h01, d);
		check_status(8'h02);
		check_depths();
	endtask

	initial begin
		seed = 32'hbd36_d8f8;
		rst_n = 1'b0;
		enq = '0;
		deq = '0;
		wb_i = '0;
		cyc_cnt = 0;
		check_cnt = 0;
		value_errs = 0;
		other_errs = 0;
		for (int q = 0; q < num_queues; q++) begin
			model[q] = '0;
			avail[q] = 0;
		end
		do_reset();
		test_after_reset();
		test_single_ops();
		test_same_queue();
		test_deq_pressure();
		test_overflow();
		$display("checks: %0d, value errors: %0d, other errors: %0d",
			check_cnt, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
src/qm_depth_pkg.sv
src/qm_depth_init_fsm.sv
src/qm_enq_latency_fifo.sv
src/qm_depth_ram.sv
src/qm_depth_update.sv
src/qm_depth_wb_port.sv
src/qm_depth_top.sv
verification/qm_depth_chk.sv
verification/qm_depth_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the queue depth testbench with Verilator and runs it
# the result comes from the log, the script fails when the pass line is missing

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module qm_depth_tb \
	-f list.f \
	-o qm_depth_sim

./obj_dir/qm_depth_sim 2>&1 | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
